// ==== williams_io.f ====
+incdir+design
design/williams_pkg.sv
design/pad_if.sv
design/pad_merge.sv
design/stick_quantize.sv
design/game_input_map.sv
design/video_blank.sv
design/audio_mixer.sv
design/williams_io_top.sv
verification/tb_williams_io.sv

// ==== build.sh ====
#!/bin/sh
# Compile the Williams I/O glue with Verilator, run the testbench and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim_williams_io.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_williams_io \
	-f williams_io.f \
	-o sim_williams_io
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_williams_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	echo "Simulation reported failing checks"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== verification/tb_williams_io.sv ====
// Self-checking testbench run as simulation top over the Williams I/O glue design files
`include "williams_cfg.svh"

module tb_williams_io;

	localparam int line_cycles = 700;
	localparam int frame_lines = 260;
	localparam int extra_lines = 20;
	// Video passes dominate the run length
	localparam int cycle_limit = (frame_lines + extra_lines) * line_cycles + 54000;
	localparam logic [15:0] fire_a = 16'h0001 << `WIO_BIT_FIRE_A;
	localparam int stick_edges [14] = '{-128, -97, -96, -65, -64, -33, -32,
		32, 33, 64, 65, 96, 97, 127};

	logic        clk_sys = 1'b0;
	logic        reset;
	logic [15:0] joy1;
	logic [15:0] joy2;
	logic [15:0] ana1;
	logic [15:0] ana2;
	logic        cfg_wr;
	logic [7:0]  cfg_index;
	logic [7:0]  cfg_data;
	logic [1:0]  ctrl_opt;
	logic        sg_state;
	logic        hs;
	logic        vs;
	logic [7:0]  dac_in;
	logic [15:0] speech_in;
	logic [7:0]  ja;
	logic [7:0]  jb;
	logic [2:0]  btn;
	logic [1:0]  sw_low;
	logic        blitter_sc2;
	logic        sinistar_mode;
	logic        landscape;
	logic        hblank;
	logic        vblank;
	logic        ce_pix;
	logic [15:0] audio_l;

	int          checks = 0;
	int          failures = 0;
	int          test_checks = 0;
	int          test_failures = 0;
	int          tests_run = 0;
	int          cycle_count = 0;
	string       cur_test;
	logic [31:0] lfsr = 32'hb719e46a;

	williams_io_top uut (.*);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: simulation ran past %0d cycles without finishing", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Random source and reference models
	////////////////////////////////////////////////////////////////////////////

	// 32-bit Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Sinistar position code of one stick axis with y mirrored
	function automatic logic [3:0] stick_code(input int v, input logic y_axis);
		logic [3:0] code;
		if (v < -`WIO_STICK_T3)      code = y_axis ? 4'd8 : 4'd0;
		else if (v < -`WIO_STICK_T2) code = y_axis ? 4'd9 : 4'd4;
		else if (v < -`WIO_STICK_T1) code = y_axis ? 4'd11 : 4'd6;
		else if (v > `WIO_STICK_T3)  code = y_axis ? 4'd0 : 4'd8;
		else if (v > `WIO_STICK_T2)  code = y_axis ? 4'd4 : 4'd9;
		else if (v > `WIO_STICK_T1)  code = y_axis ? 4'd6 : 4'd11;
		else                         code = 4'(`WIO_STICK_CENTER);
		return code;
	endfunction

	// Expected JA under Sinistar with digital directions used when an axis rests
	function automatic logic [7:0] sinistar_ja(input logic [15:0] ana, input logic [15:0] pad);
		int         x;
		int         y;
		logic [3:0] cx;
		logic [3:0] cy;
		x = $signed(ana[7:0]);
		y = $signed(ana[15:8]);
		cx = stick_code(x, 1'b0);
		cy = stick_code(y, 1'b1);
		if (cx == 4'(`WIO_STICK_CENTER))
			cx = pad[`WIO_BIT_LEFT] ? 4'd0 : pad[`WIO_BIT_RIGHT] ? 4'd8 : cx;
		if (cy == 4'(`WIO_STICK_CENTER))
			cy = pad[`WIO_BIT_DOWN] ? 4'd0 : pad[`WIO_BIT_UP] ? 4'd8 : cy;
		return ~{cx, cy};
	endfunction

	// Mix of average and speech with speech boosted x4 and clipped when asked
	function automatic logic [15:0] audio_expect(input logic [7:0] avg, input logic [15:0] sp,
	                                             input logic boost);
		int s;
		int term;
		term = int'(sp);
		if (boost) begin
			s = (int'(sp) - 32768) * 4;
			if (s > 32767) s = 32767;
			if (s < -32768) s = -32768;
			term = s + 32768;
		end
		return 16'((int'(avg) * 256 + term) >> 3);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bookkeeping and stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic begin_test(input string name);
		cur_test = name;
		test_checks = checks;
		test_failures = failures;
	endtask

	task automatic end_test();
		tests_run++;
		$display("Test %s done: %0d checks, %0d failed", cur_test,
		         checks - test_checks, failures - test_failures);
	endtask

	task automatic check_value(input string label, input logic [31:0] expected,
	                           input logic [31:0] actual);
		checks++;
		assert (expected === actual) else begin
			$display("Fail %s (%s): expected 0x%0h, actual 0x%0h", cur_test, label,
			         expected, actual);
			failures++;
		end
	endtask

	// Let n edges pass, then sample on the falling edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic load_game(input williams_pkg::game_e g);
		@(posedge clk_sys);
		cfg_wr    <= 1'b1;
		cfg_index <= 8'(`WIO_GAME_INDEX);
		cfg_data  <= g;
		@(posedge clk_sys);
		cfg_wr    <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic drive_pads(input logic [15:0] a, input logic [15:0] b);
		@(posedge clk_sys);
		joy1 <= a;
		joy2 <= b;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_values();
		begin_test("reset");
		@(negedge clk_sys);
		check_value("ja", 8'hff, ja);
		check_value("jb", 8'hff, jb);
		check_value("btn", 3'b000, btn);
		check_value("hblank", 1'b0, hblank);
		check_value("vblank", 1'b0, vblank);
		check_value("landscape", 1'b1, landscape);
		check_value("blitter_sc2", 1'b0, blitter_sc2);
		check_value("audio_l", 16'h0000, audio_l);
		end_test();
	endtask

	task automatic joust_mapping();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] m;
		logic [7:0]  exp_a;
		logic [7:0]  exp_b;
		begin_test("joust");
		load_game(williams_pkg::joust);
		check_value("game", williams_pkg::joust, uut.game);
		for (int n = 0; n < 24; n++) begin
			a = draw_bits(16);
			b = draw_bits(16);
			m = a | b;
			exp_a = ~{5'b00000, a[`WIO_BIT_FIRE_A], a[`WIO_BIT_RIGHT], a[`WIO_BIT_LEFT]};
			exp_b = ~{5'b00000, b[`WIO_BIT_FIRE_A], b[`WIO_BIT_RIGHT], b[`WIO_BIT_LEFT]};
			drive_pads(a, b);
			wait_cycles(1);
			check_value("ja", exp_a, ja);
			check_value("jb", exp_b, jb);
			check_value("btn", {m[`WIO_BIT_START2], m[`WIO_BIT_START1], m[`WIO_BIT_COIN]}, btn);
			check_value("sw_low", {m[`WIO_BIT_ADVANCE], m[`WIO_BIT_AUTOUP]}, sw_low);
		end
		// Strobe to another index leaves the game alone
		@(posedge clk_sys);
		cfg_wr    <= 1'b1;
		cfg_index <= 8'd2;
		cfg_data  <= williams_pkg::robotron;
		@(posedge clk_sys);
		cfg_wr    <= 1'b0;
		wait_cycles(0);
		check_value("game kept", williams_pkg::joust, uut.game);
		// Splat raises the second blitter select
		load_game(williams_pkg::splat);
		wait_cycles(1);
		check_value("blitter_sc2", 1'b1, blitter_sc2);
		end_test();
	endtask

	task automatic merge_tracking();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] m;
		logic [7:0]  exp_j;
		begin_test("merge");
		load_game(williams_pkg::bubbles);
		for (int n = 0; n < 24; n++) begin
			a = draw_bits(16);
			b = draw_bits(16);
			m = a | b;
			exp_j = ~{4'b0000, m[`WIO_BIT_RIGHT], m[`WIO_BIT_LEFT],
			          m[`WIO_BIT_DOWN], m[`WIO_BIT_UP]};
			drive_pads(a, b);
			wait_cycles(1);
			check_value("ja", exp_j, ja);
			check_value("jb", exp_j, jb);
		end
		check_value("blitter_sc2", 1'b0, blitter_sc2);
		load_game(williams_pkg::sinistar);
		@(posedge clk_sys);
		ana1 <= 16'h0064;
		ana2 <= 16'h9c9c;
		// Player 1 active first, then only player 2 moves
		drive_pads(fire_a, 16'h0000);
		wait_cycles(2);
		check_value("player 1 stick", sinistar_ja(16'h0064, fire_a), ja);
		drive_pads(16'h0000, fire_a);
		wait_cycles(2);
		check_value("player 2 stick", sinistar_ja(16'h9c9c, fire_a), ja);
		end_test();
	endtask

	task automatic stick_quantization();
		logic [15:0] a;
		logic [15:0] pad;
		begin_test("stick");
		drive_pads(fire_a, 16'h0000);
		for (int n = 0; n < 44; n++) begin
			if (n < 14) a = {8'(stick_edges[13 - n]), 8'(stick_edges[n])};
			else        a = draw_bits(16);
			@(posedge clk_sys);
			ana1 <= a;
			wait_cycles(2);
			check_value("ja analog", sinistar_ja(a, fire_a), ja);
		end
		@(posedge clk_sys);
		ana1 <= 16'h0000;
		for (int n = 0; n < 3; n++) begin
			pad = fire_a;
			if (n == 0) pad = pad | (16'h0001 << `WIO_BIT_LEFT) | (16'h0001 << `WIO_BIT_DOWN);
			if (n == 1) pad = pad | (16'h0001 << `WIO_BIT_RIGHT) | (16'h0001 << `WIO_BIT_UP);
			drive_pads(pad, 16'h0000);
			wait_cycles(2);
			check_value("ja digital", sinistar_ja(16'h0000, pad), ja);
		end
		check_value("sinistar_mode", 1'b1, sinistar_mode);
		check_value("landscape", 1'b0, landscape);
		end_test();
	endtask

	task automatic blanking();
		int   p;
		int   rows;
		logic prev_ce;
		logic exp_vb;
		begin_test("video");
		prev_ce = ce_pix;
		for (int frame = 0; frame < 2; frame++) begin
			rows = (frame == 0) ? frame_lines : extra_lines;
			for (int row = 0; row < rows; row++) begin
				for (int k = 0; k < line_cycles; k++) begin
					@(posedge clk_sys);
					hs <= (k < 40);
					vs <= (row < 3);
					@(negedge clk_sys);
					// Pixel count restarts one edge after hs goes high
					p = (k + line_cycles - 1) % line_cycles;
					if (frame > 0 || row > 0) begin
						check_value("hblank", (p > 2 * `WIO_HB_START) || (p <= 2 * `WIO_HB_END),
						            hblank);
						check_value("ce_pix toggle", !prev_ce, ce_pix);
					end
					if (k == line_cycles / 2) begin
						exp_vb = (row >= `WIO_VB_START) || (frame > 0 && row < `WIO_VB_END);
						check_value("vblank", exp_vb, vblank);
					end
					prev_ce = ce_pix;
				end
			end
		end
		@(posedge clk_sys);
		hs <= 1'b0;
		vs <= 1'b0;
		end_test();
	endtask

	task automatic check_speech(input logic [7:0] avg, input logic [15:0] sp, input logic boost);
		@(posedge clk_sys);
		speech_in <= sp;
		wait_cycles(0);
		check_value("audio_l", audio_expect(avg, sp, boost), audio_l);
	endtask

	task automatic audio_mix();
		logic [7:0] d;
		begin_test("audio");
		// Sinistar still selected from the stick test
		d = draw_bits(8);
		@(posedge clk_sys);
		dac_in    <= d;
		speech_in <= 16'h8000;
		wait_cycles(512);
		check_speech(d, 16'hf000, 1'b1);
		check_speech(d, 16'h1000, 1'b1);
		check_speech(d, 16'h8123, 1'b1);
		check_speech(d, 16'h7e00, 1'b1);
		for (int n = 0; n < 4; n++) check_speech(d, draw_bits(16), 1'b1);
		load_game(williams_pkg::robotron);
		d = draw_bits(8);
		@(posedge clk_sys);
		dac_in <= d;
		wait_cycles(512);
		check_speech(d, 16'hf000, 1'b0);
		for (int n = 0; n < 6; n++) check_speech(d, draw_bits(16), 1'b0);
		end_test();
	endtask

	initial begin
		reset     = 1'b1;
		joy1      = '0;
		joy2      = '0;
		ana1      = '0;
		ana2      = '0;
		cfg_wr    = 1'b0;
		cfg_index = '0;
		cfg_data  = '0;
		ctrl_opt  = 2'b00;
		sg_state  = 1'b0;
		hs        = 1'b0;
		vs        = 1'b0;
		dac_in    = '0;
		speech_in = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;

		reset_values();
		joust_mapping();
		merge_tracking();
		stick_quantization();
		blanking();
		audio_mix();

		$display("Summary: %0d tests, %0d checks, %0d failures", tests_run, checks, failures);
		if (failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== design/williams_io_top.sv ====
// Top level of the Williams control, video timing and audio glue; wires the stages together
`include "williams_cfg.svh"

module williams_io_top (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`WIO_PAD_W-1:0] joy1,
	input  logic [`WIO_PAD_W-1:0] joy2,
	input  logic [`WIO_ANA_W-1:0] ana1,
	input  logic [`WIO_ANA_W-1:0] ana2,
	input  logic                  cfg_wr,
	input  logic [`WIO_CFG_W-1:0] cfg_index,
	input  logic [`WIO_CFG_W-1:0] cfg_data,
	input  logic [1:0]            ctrl_opt,
	input  logic                  sg_state,
	input  logic                  hs,
	input  logic                  vs,
	input  logic [`WIO_DAC_W-1:0] dac_in,
	input  logic [`WIO_AUD_W-1:0] speech_in,
	output logic [7:0]            ja,
	output logic [7:0]            jb,
	output logic [2:0]            btn,
	output logic [1:0]            sw_low,
	output logic                  blitter_sc2,
	output logic                  sinistar_mode,
	output logic                  landscape,
	output logic                  hblank,
	output logic                  vblank,
	output logic                  ce_pix,
	output logic [`WIO_AUD_W-1:0] audio_l
);

	williams_pkg::game_e game;
	logic [3:0]          pos_x;
	logic [3:0]          pos_y;

	pad_if pads ();

	pad_merge u_pad_merge (
		.clk_sys (clk_sys),
		.reset   (reset),
		.joy1    (joy1),
		.joy2    (joy2),
		.ana1    (ana1),
		.ana2    (ana2),
		.pads    (pads.src)
	);

	stick_quantize u_stick_quantize (
		.pads  (pads.dst),
		.pos_x (pos_x),
		.pos_y (pos_y)
	);

	game_input_map u_game_input_map (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.pads          (pads.dst),
		.pos_x         (pos_x),
		.pos_y         (pos_y),
		.cfg_wr        (cfg_wr),
		.cfg_index     (cfg_index),
		.cfg_data      (cfg_data),
		.ctrl_opt      (ctrl_opt),
		.sg_state      (sg_state),
		.game          (game),
		.ja            (ja),
		.jb            (jb),
		.btn           (btn),
		.sw_low        (sw_low),
		.blitter_sc2   (blitter_sc2),
		.sinistar_mode (sinistar_mode),
		.landscape     (landscape)
	);

	video_blank u_video_blank (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (hs),
		.vs      (vs),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix)
	);

	audio_mixer u_audio_mixer (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.game      (game),
		.dac_in    (dac_in),
		.speech_in (speech_in),
		.audio_l   (audio_l)
	);

endmodule

// ==== design/audio_mixer.sv ====
// Averages the sound DAC, boosts Sinistar speech with saturation and mixes both into the output
`include "williams_cfg.svh"

module audio_mixer (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  williams_pkg::game_e   game,
	input  logic [`WIO_DAC_W-1:0] dac_in,
	input  logic [`WIO_AUD_W-1:0] speech_in,
	output logic [`WIO_AUD_W-1:0] audio_l
);

	localparam int acc_w = `WIO_DAC_W + `WIO_AVG_LOG2;

	logic [`WIO_AVG_LOG2-1:0] cnt;
	logic [acc_w-1:0]         accum;
	logic [acc_w-1:0]         accum_sum;
	logic [`WIO_DAC_W-1:0]    average;
	logic signed [15:0]       speech_s;
	logic signed [17:0]       speech_x4;
	logic signed [15:0]       speech_sat;
	logic [15:0]              speech_term;
	logic [16:0]              mix;

	////////////////////////////////////////////////////////////////////////////
	// Boxcar average of the DAC over 256 clocks
	////////////////////////////////////////////////////////////////////////////

	assign accum_sum = accum + acc_w'(dac_in);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt     <= '0;
			accum   <= '0;
			average <= '0;
		end else begin
			cnt <= cnt + 1'b1;
			if (&cnt) begin
				// Last sample joins the sum, then divide by 256
				average <= accum_sum[acc_w-1 -: `WIO_DAC_W];
				accum   <= '0;
			end else begin
				accum <= accum_sum;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Speech boost
	////////////////////////////////////////////////////////////////////////////

	// Offset binary to two's complement
	assign speech_s  = $signed({~speech_in[15], speech_in[14:0]});
	assign speech_x4 = $signed({speech_s, 2'b00});

	always_comb begin
		if (speech_x4 > 18'sd32767) begin
			speech_sat = 16'sh7fff;
		end else if (speech_x4 < -18'sd32768) begin
			speech_sat = 16'sh8000;
		end else begin
			speech_sat = speech_x4[15:0];
		end
	end

	assign speech_term = (game == williams_pkg::sinistar) ?
	                     {~speech_sat[15], speech_sat[14:0]} : speech_in;

	// Average sits in the top byte of the mix
	assign mix     = {1'b0, average, 8'h00} + {1'b0, speech_term};
	assign audio_l = {2'b00, mix[16:3]};

endmodule

// ==== design/video_blank.sv ====
// Derives the pixel enable and the HBlank and VBlank flags from the board's sync pulses
`include "williams_cfg.svh"

module video_blank (
	input  logic clk_sys,
	input  logic reset,
	input  logic hs,
	input  logic vs,
	output logic hblank,
	output logic vblank,
	output logic ce_pix
);

	localparam logic [`WIO_CNT_W-2:0] hb_start = (`WIO_CNT_W-1)'(`WIO_HB_START);
	localparam logic [`WIO_CNT_W-2:0] hb_end   = (`WIO_CNT_W-1)'(`WIO_HB_END);
	localparam logic [`WIO_CNT_W-1:0] vb_start = `WIO_CNT_W'(`WIO_VB_START);
	localparam logic [`WIO_CNT_W-1:0] vb_end   = `WIO_CNT_W'(`WIO_VB_END);

	logic [`WIO_CNT_W-1:0] pcnt;
	logic [`WIO_CNT_W-1:0] lcnt;
	logic                  hs_d;
	logic                  vs_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pcnt   <= '0;
			lcnt   <= '0;
			hs_d   <= 1'b0;
			vs_d   <= 1'b0;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end else begin
			hs_d <= hs;
			// Both counters hold at all ones if sync goes missing
			if (~&pcnt) pcnt <= pcnt + 1'b1;

			// vs only looked at on line starts
			if (hs & ~hs_d) begin
				pcnt <= '0;
				vs_d <= vs;
				if (vs & ~vs_d) begin
					lcnt <= '0;
				end else if (~&lcnt) begin
					lcnt <= lcnt + 1'b1;
				end
			end

			if (pcnt[`WIO_CNT_W-1:1] == hb_start) hblank <= 1'b1;
			if (pcnt[`WIO_CNT_W-1:1] == hb_end)   hblank <= 1'b0;
			if (lcnt == vb_start) vblank <= 1'b1;
			if (lcnt == vb_end)   vblank <= 1'b0;
		end
	end

	// One pixel every two system clocks
	assign ce_pix = pcnt[0];

endmodule

// ==== design/game_input_map.sv ====
// Holds the game select and registers the active-low JA, JB and BTN words and board flags per game
`include "williams_cfg.svh"

module game_input_map (
	input  logic                  clk_sys,
	input  logic                  reset,
	pad_if.dst                    pads,
	input  logic [3:0]            pos_x,
	input  logic [3:0]            pos_y,
	input  logic                  cfg_wr,
	input  logic [`WIO_CFG_W-1:0] cfg_index,
	input  logic [`WIO_CFG_W-1:0] cfg_data,
	input  logic [1:0]            ctrl_opt,
	input  logic                  sg_state,
	output williams_pkg::game_e   game,
	output logic [7:0]            ja,
	output logic [7:0]            jb,
	output logic [2:0]            btn,
	output logic [1:0]            sw_low,
	output logic                  blitter_sc2,
	output logic                  sinistar_mode,
	output logic                  landscape
);

	localparam logic [`WIO_CFG_W-1:0] game_index = `WIO_CFG_W'(`WIO_GAME_INDEX);

	williams_pkg::ctrl_mode_e mode;
	logic [`WIO_PAD_W-1:0]    p1;
	logic [`WIO_PAD_W-1:0]    p2;
	logic [`WIO_PAD_W-1:0]    pm;
	logic [3:0]               dir1;
	logic [3:0]               dir2;
	logic [3:0]               dir_m;
	logic [3:0]               fire_m;
	logic                     sg_mid;
	logic                     sg_low;
	logic [7:0]               ja_next;
	logic [7:0]               jb_next;
	logic [2:0]               btn_next;
	logic                     sc2_next;
	logic                     sin_next;
	logic                     land_next;

	assign p1 = pads.pad1;
	assign p2 = pads.pad2;
	assign pm = pads.pad_or;

	// Directions packed as {right, left, down, up}
	assign dir1  = {p1[`WIO_BIT_RIGHT], p1[`WIO_BIT_LEFT], p1[`WIO_BIT_DOWN], p1[`WIO_BIT_UP]};
	assign dir2  = {p2[`WIO_BIT_RIGHT], p2[`WIO_BIT_LEFT], p2[`WIO_BIT_DOWN], p2[`WIO_BIT_UP]};
	assign dir_m = {pm[`WIO_BIT_RIGHT], pm[`WIO_BIT_LEFT], pm[`WIO_BIT_DOWN], pm[`WIO_BIT_UP]};

	// Robotron fire buttons laid out as a second stick
	assign fire_m = {pm[`WIO_BIT_FIRE_A], pm[`WIO_BIT_FIRE_D],
	                 pm[`WIO_BIT_FIRE_B], pm[`WIO_BIT_FIRE_C]};

	always_comb begin
		if (game == williams_pkg::stargate && ctrl_opt == 2'b10) begin
			mode = williams_pkg::ctrl_fire_e;
		end else if (game == williams_pkg::robotron && ctrl_opt[1]) begin
			mode = williams_pkg::ctrl_twin;
		end else if (ctrl_opt[0]) begin
			mode = williams_pkg::ctrl_move_fire;
		end else begin
			mode = williams_pkg::ctrl_single;
		end
	end

	// Stargate thrust and reverse steered by the ship direction in move-with-fire mode
	assign sg_mid = (mode == williams_pkg::ctrl_fire_e)    ? pm[`WIO_BIT_FIRE_E] :
	                (mode == williams_pkg::ctrl_move_fire) ?
	                (sg_state ? pm[`WIO_BIT_RIGHT] : pm[`WIO_BIT_LEFT]) :
	                (pm[`WIO_BIT_LEFT] | pm[`WIO_BIT_RIGHT]);
	assign sg_low = (mode == williams_pkg::ctrl_move_fire) ?
	                (sg_state ? pm[`WIO_BIT_LEFT] : pm[`WIO_BIT_RIGHT]) : pm[`WIO_BIT_FIRE_B];

	////////////////////////////////////////////////////////////////////////////
	// Per-game packing into active-low words
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		ja_next   = 8'hff;
		jb_next   = 8'hff;
		btn_next  = {pm[`WIO_BIT_START1], pm[`WIO_BIT_START2], pm[`WIO_BIT_COIN]};
		sc2_next  = 1'b0;
		sin_next  = 1'b0;
		land_next = 1'b1;
		case (game)
			williams_pkg::robotron: begin
				ja_next = ~{(mode == williams_pkg::ctrl_twin)      ? dir2  :
				            (mode == williams_pkg::ctrl_move_fire) ? dir_m : fire_m,
				            (mode == williams_pkg::ctrl_twin)      ? dir1  : dir_m};
				jb_next = ja_next;
			end
			williams_pkg::joust: begin
				btn_next = {pm[`WIO_BIT_START2], pm[`WIO_BIT_START1], pm[`WIO_BIT_COIN]};
				ja_next  = ~{5'b00000, p1[`WIO_BIT_FIRE_A], p1[`WIO_BIT_RIGHT], p1[`WIO_BIT_LEFT]};
				jb_next  = ~{5'b00000, p2[`WIO_BIT_FIRE_A], p2[`WIO_BIT_RIGHT], p2[`WIO_BIT_LEFT]};
			end
			williams_pkg::splat: begin
				sc2_next = 1'b1;
				ja_next  = ~{(mode == williams_pkg::ctrl_move_fire) ? dir1 :
				             {p1[`WIO_BIT_FIRE_A], p1[`WIO_BIT_FIRE_D],
				              p1[`WIO_BIT_FIRE_B], p1[`WIO_BIT_FIRE_C]}, dir1};
				jb_next  = ~{(mode == williams_pkg::ctrl_move_fire) ? dir2 :
				             {p2[`WIO_BIT_FIRE_A], p2[`WIO_BIT_FIRE_D],
				              p2[`WIO_BIT_FIRE_B], p2[`WIO_BIT_FIRE_C]}, dir2};
			end
			williams_pkg::bubbles: begin
				btn_next = {pm[`WIO_BIT_START2], pm[`WIO_BIT_START1], pm[`WIO_BIT_COIN]};
				ja_next  = ~{4'b0000, dir_m};
				jb_next  = ja_next;
			end
			williams_pkg::stargate: begin
				btn_next = {pm[`WIO_BIT_START2], pm[`WIO_BIT_START1], pm[`WIO_BIT_COIN]};
				ja_next  = ~{pm[`WIO_BIT_FIRE_F], pm[`WIO_BIT_UP], pm[`WIO_BIT_DOWN], sg_mid,
				             pm[`WIO_BIT_FIRE_D], pm[`WIO_BIT_FIRE_C], sg_low, pm[`WIO_BIT_FIRE_A]};
				jb_next  = ja_next;
			end
			williams_pkg::alienar: begin
				ja_next = ~{2'b00, p1[`WIO_BIT_FIRE_B], p1[`WIO_BIT_FIRE_A], dir1};
				jb_next = ~{2'b00, p2[`WIO_BIT_FIRE_B], p2[`WIO_BIT_FIRE_A], dir2};
			end
			williams_pkg::sinistar: begin
				sin_next  = 1'b1;
				land_next = 1'b0;
				ja_next   = ~{pos_x, pos_y};
				jb_next   = ja_next;
			end
			williams_pkg::playball: begin
				land_next = 1'b0;
				btn_next  = {2'b00, pm[`WIO_BIT_COIN]};
				ja_next   = ~{4'b0000, pm[`WIO_BIT_START2], pm[`WIO_BIT_RIGHT],
				              pm[`WIO_BIT_LEFT], pm[`WIO_BIT_START1]};
				jb_next   = ja_next;
			end
			default: begin
				btn_next = 3'b000;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game          <= williams_pkg::robotron;
			ja            <= 8'hff;
			jb            <= 8'hff;
			btn           <= 3'b000;
			sw_low        <= 2'b00;
			blitter_sc2   <= 1'b0;
			sinistar_mode <= 1'b0;
			landscape     <= 1'b1;
		end else begin
			if (cfg_wr && cfg_index == game_index) begin
				game <= williams_pkg::game_e'(cfg_data);
			end
			ja            <= ja_next;
			jb            <= jb_next;
			btn           <= btn_next;
			sw_low        <= {pm[`WIO_BIT_ADVANCE], pm[`WIO_BIT_AUTOUP]};
			blitter_sc2   <= sc2_next;
			sinistar_mode <= sin_next;
			landscape     <= land_next;
		end
	end

endmodule

// ==== design/stick_quantize.sv ====
// Converts the analog stick, or the digital directions at rest, into Sinistar's position codes
`include "williams_cfg.svh"

module stick_quantize (
	pad_if.dst         pads,
	output logic [3:0] pos_x,
	output logic [3:0] pos_y
);

	localparam logic signed [8:0] t1 = 9'(`WIO_STICK_T1);
	localparam logic signed [8:0] t2 = 9'(`WIO_STICK_T2);
	localparam logic signed [8:0] t3 = 9'(`WIO_STICK_T3);
	localparam logic [3:0] center = 4'(`WIO_STICK_CENTER);

	logic signed [8:0] x_ext;
	logic signed [8:0] y_neg;
	logic [3:0]        ana_code_x;
	logic [3:0]        ana_code_y;
	logic [3:0]        dig_code_x;
	logic [3:0]        dig_code_y;

	// Threshold table of the x axis; y uses it on the negated value
	function automatic logic [3:0] axis_code(input logic signed [8:0] v);
		logic [3:0] code;
		if (v < -t3)       code = 4'd0;
		else if (v < -t2)  code = 4'd4;
		else if (v < -t1)  code = 4'd6;
		else if (v > t3)   code = 4'd8;
		else if (v > t2)   code = 4'd9;
		else if (v > t1)   code = 4'd11;
		else               code = center;
		return code;
	endfunction

	// Nine bits so that -128 negates cleanly
	assign x_ext = pads.ana_x;
	assign y_neg = -$signed({pads.ana_y[7], pads.ana_y});

	assign ana_code_x = axis_code(x_ext);
	assign ana_code_y = axis_code(y_neg);

	// Digital fallback
	assign dig_code_x = pads.pad_or[`WIO_BIT_LEFT]  ? 4'd0 :
	                    pads.pad_or[`WIO_BIT_RIGHT] ? 4'd8 : center;
	assign dig_code_y = pads.pad_or[`WIO_BIT_DOWN]  ? 4'd0 :
	                    pads.pad_or[`WIO_BIT_UP]    ? 4'd8 : center;

	assign pos_x = (ana_code_x == center) ? dig_code_x : ana_code_x;
	assign pos_y = (ana_code_y == center) ? dig_code_y : ana_code_y;

endmodule

// ==== design/pad_merge.sv ====
// Merges the two player pads and forwards the analog stick of whoever moved last
`include "williams_cfg.svh"

module pad_merge (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`WIO_PAD_W-1:0] joy1,
	input  logic [`WIO_PAD_W-1:0] joy2,
	input  logic [`WIO_ANA_W-1:0] ana1,
	input  logic [`WIO_ANA_W-1:0] ana2,
	pad_if.src                    pads
);

	logic                  player2;
	logic [`WIO_ANA_W-1:0] ana_sel;

	// Last active player with priority to player 1 when both press
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			player2 <= 1'b0;
		end else if (|joy1) begin
			player2 <= 1'b0;
		end else if (|joy2) begin
			player2 <= 1'b1;
		end
	end

	assign ana_sel = player2 ? ana2 : ana1;

	assign pads.pad1   = joy1;
	assign pads.pad2   = joy2;
	assign pads.pad_or = joy1 | joy2;

	// Low byte is x, high byte is y
	assign pads.ana_x = $signed(ana_sel[7:0]);
	assign pads.ana_y = $signed(ana_sel[15:8]);

endmodule

// ==== design/pad_if.sv ====
// Pad bundle from the merge stage to the stick quantizer and the per-game input mapping
`include "williams_cfg.svh"

interface pad_if;

	// Raw pad of each player
	logic [`WIO_PAD_W-1:0] pad1;
	logic [`WIO_PAD_W-1:0] pad2;

	// Both players ORed together
	logic [`WIO_PAD_W-1:0] pad_or;

	// Stick of the last active player
	logic signed [7:0] ana_x;
	logic signed [7:0] ana_y;

	modport src (output pad1, pad2, pad_or, ana_x, ana_y);
	modport dst (input pad1, pad2, pad_or, ana_x, ana_y);

endinterface

// ==== design/williams_pkg.sv ====
// Game select and control-mode types shared by the input mapping, the audio mixer and the testbench
package williams_pkg;

	// Game select as loaded from the configuration port
	typedef enum logic [7:0] {
		robotron = 8'd0,
		joust    = 8'd1,
		splat    = 8'd2,
		bubbles  = 8'd3,
		stargate = 8'd4,
		alienar  = 8'd5,
		sinistar = 8'd6,
		playball = 8'd7
	} game_e;

	// Control scheme derived from the option port
	// Fire-E only exists on Stargate, twin stick only on Robotron
	typedef enum logic [1:0] {
		ctrl_single    = 2'd0,
		ctrl_move_fire = 2'd1,
		ctrl_twin      = 2'd2,
		ctrl_fire_e    = 2'd3
	} ctrl_mode_e;

endpackage

// ==== design/williams_cfg.svh ====
// Widths, thresholds and pad bit indices of the Williams I/O glue that each design file includes
`ifndef WILLIAMS_CFG_SVH
`define WILLIAMS_CFG_SVH

// Pad word layout with one bit per control
`define WIO_PAD_W        16
`define WIO_BIT_RIGHT    0
`define WIO_BIT_LEFT     1
`define WIO_BIT_DOWN     2
`define WIO_BIT_UP       3
`define WIO_BIT_FIRE_A   4
`define WIO_BIT_FIRE_B   5
`define WIO_BIT_FIRE_C   6
`define WIO_BIT_FIRE_D   7
`define WIO_BIT_FIRE_E   8
`define WIO_BIT_FIRE_F   9
`define WIO_BIT_START1   10
`define WIO_BIT_START2   11
`define WIO_BIT_COIN     12
`define WIO_BIT_ADVANCE  13
`define WIO_BIT_AUTOUP   14

// Analog stick word is {y, x} as two signed bytes
`define WIO_ANA_W        16

// Configuration port
`define WIO_CFG_W        8
`define WIO_GAME_INDEX   1

// Sinistar stick quantizer
`define WIO_STICK_T1     32
`define WIO_STICK_T2     64
`define WIO_STICK_T3     96
`define WIO_STICK_CENTER 7

// Video timing with horizontal values in half-pixel-counter units
`define WIO_CNT_W        11
`define WIO_HB_START     336
`define WIO_HB_END       40
`define WIO_VB_START     254
`define WIO_VB_END       14

// Audio path
`define WIO_DAC_W        8
`define WIO_AUD_W        16
`define WIO_AVG_LOG2     8

`endif
